// File: verilog/aud_pkg.sv
package aud_pkg;

    localparam int SAMPLE_W = 16;
    localparam int ADDR_W   = 8;
    localparam int DEPTH    = 1 << ADDR_W;

    // host command opcodes
    typedef enum logic [1:0] {
        OP_RECORD = 2'd0,
        OP_PLAY   = 2'd1,
        OP_PAUSE  = 2'd2,
        OP_STOP   = 2'd3
    } aud_op_e;

    typedef enum logic [1:0] {
        MODE_IDLE  = 2'd0,
        MODE_REC   = 2'd1,
        MODE_PLAY  = 2'd2,
        MODE_PAUSE = 2'd3
    } aud_mode_e;

    typedef enum logic [1:0] {
        R_IDLE  = 2'd0,
        R_WAIT  = 2'd1,   // waiting for left half
        R_SHIFT = 2'd2,
        R_PAUSE = 2'd3
    } rec_state_e;

    typedef enum logic [2:0] {
        P_IDLE    = 3'd0,
        P_WAIT_L  = 3'd1,
        P_SHIFT_L = 3'd2,
        P_WAIT_R  = 3'd3,
        P_SHIFT_R = 3'd4,
        P_PAUSE   = 3'd5
    } ply_state_e;

endpackage

// File: verilog/aud_sample_buf.sv
`timescale 1ns/1ps

module aud_sample_buf (
    input  logic                          i_bclk,
    input  logic                          i_wr_en,
    input  logic [aud_pkg::ADDR_W-1:0]    i_wr_addr,
    input  logic [aud_pkg::SAMPLE_W-1:0]  i_wr_data,
    input  logic [aud_pkg::ADDR_W-1:0]    i_rd_addr,
    output logic [aud_pkg::SAMPLE_W-1:0]  o_rd_data
);

    logic [aud_pkg::SAMPLE_W-1:0] mem [aud_pkg::DEPTH];

    always_ff @(posedge i_bclk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge i_bclk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// File: verilog/aud_recorder.sv
`timescale 1ns/1ps

module aud_recorder (
    input  logic                          i_bclk,
    input  logic                          i_rst_n,
    input  logic                          i_daclrck,
    input  logic                          i_adcdat,
    input  logic                          i_start,
    input  logic                          i_pause,
    input  logic                          i_stop,
    output logic                          o_wr_en,
    output logic [aud_pkg::ADDR_W-1:0]    o_wr_addr,
    output logic [aud_pkg::SAMPLE_W-1:0]  o_wr_data,
    output logic [aud_pkg::ADDR_W:0]      o_rec_len,
    output logic                          o_full
);

    aud_pkg::rec_state_e               state_r, state_w;
    logic [4:0]                        bit_cnt_r, bit_cnt_w;
    logic [aud_pkg::ADDR_W:0]          len_r, len_w;
    logic [aud_pkg::SAMPLE_W-2:0]      shift_r;
    logic [aud_pkg::SAMPLE_W-1:0]      sample_w;
    logic                              lrck_d_r;
    logic                              lrck_fall;
    logic                              wr_en_w, full_w;

    assign lrck_fall = lrck_d_r & ~i_daclrck;
    assign sample_w  = {shift_r, i_adcdat};   // last 16 bits seen
    assign o_rec_len = len_r;

    always_comb begin
        state_w   = state_r;
        bit_cnt_w = bit_cnt_r;
        len_w     = len_r;
        wr_en_w   = 1'b0;
        full_w    = 1'b0;

        case (state_r)
            aud_pkg::R_IDLE: begin
                if (i_start) begin
                    state_w = aud_pkg::R_WAIT;
                    len_w   = '0;
                end
            end
            aud_pkg::R_WAIT: begin
                if (i_stop) begin
                    state_w = aud_pkg::R_IDLE;
                end else if (i_pause) begin
                    state_w = aud_pkg::R_PAUSE;
                end else if (lrck_fall) begin
                    state_w   = aud_pkg::R_SHIFT;
                    bit_cnt_w = 5'd1;   // discarded I2S bit
                end
            end
            aud_pkg::R_SHIFT: begin
                if (i_stop) begin
                    state_w = aud_pkg::R_IDLE;
                end else if (i_pause) begin
                    state_w = aud_pkg::R_PAUSE;
                end else if (bit_cnt_r == 5'd16) begin
                    // 17th bit arrives now
                    wr_en_w = 1'b1;
                    len_w   = len_r + 1'b1;
                    if (len_w == aud_pkg::DEPTH) begin
                        full_w  = 1'b1;
                        state_w = aud_pkg::R_IDLE;
                    end else begin
                        state_w = aud_pkg::R_WAIT;
                    end
                end else begin
                    bit_cnt_w = bit_cnt_r + 1'b1;
                end
            end
            aud_pkg::R_PAUSE: begin
                if (i_stop) begin
                    state_w = aud_pkg::R_IDLE;
                end else if (i_start) begin
                    state_w = aud_pkg::R_WAIT;   // resume, keep count
                end
            end
            default: state_w = aud_pkg::R_IDLE;
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= aud_pkg::R_IDLE;
            bit_cnt_r <= '0;
            len_r     <= '0;
            lrck_d_r  <= 1'b0;
            o_wr_en   <= 1'b0;
            o_full    <= 1'b0;
        end else begin
            state_r   <= state_w;
            bit_cnt_r <= bit_cnt_w;
            len_r     <= len_w;
            lrck_d_r  <= i_daclrck;
            o_wr_en   <= wr_en_w;
            o_full    <= full_w;
        end
    end

    always_ff @(posedge i_bclk) begin
        shift_r <= sample_w[aud_pkg::SAMPLE_W-2:0];
        if (wr_en_w) begin
            o_wr_data <= sample_w;
            o_wr_addr <= len_r[aud_pkg::ADDR_W-1:0];
        end
    end

endmodule

// File: verilog/aud_player.sv
`timescale 1ns/1ps

module aud_player (
    input  logic                          i_bclk,
    input  logic                          i_rst_n,
    input  logic                          i_daclrck,
    input  logic                          i_start,
    input  logic                          i_pause,
    input  logic                          i_stop,
    input  logic [aud_pkg::ADDR_W:0]      i_rec_len,
    input  logic [aud_pkg::SAMPLE_W-1:0]  i_rd_data,
    output logic [aud_pkg::ADDR_W-1:0]    o_rd_addr,
    output logic                          o_dacdat,
    output logic                          o_done
);

    aud_pkg::ply_state_e            state_r, state_w;
    logic [3:0]                     bit_cnt_r, bit_cnt_w;
    logic [aud_pkg::ADDR_W-1:0]     addr_w;
    logic                           dac_w, done_w;
    logic                           lrck_d_r;
    logic                           lrck_fall, lrck_rise;
    logic                           last_word;
    logic                           active;

    assign lrck_fall = lrck_d_r & ~i_daclrck;
    assign lrck_rise = ~lrck_d_r & i_daclrck;
    assign last_word = ({1'b0, o_rd_addr} + 1'b1) == i_rec_len;
    assign active    = (state_r != aud_pkg::P_IDLE) && (state_r != aud_pkg::P_PAUSE);

    always_comb begin
        state_w   = state_r;
        bit_cnt_w = bit_cnt_r;
        addr_w    = o_rd_addr;
        dac_w     = 1'b0;   // silent outside the 16 data bits
        done_w    = 1'b0;

        case (state_r)
            aud_pkg::P_IDLE: begin
                if (i_start) begin
                    addr_w = '0;   // word 0 comes out of the buffer next cycle
                    if (i_rec_len == '0) begin
                        done_w = 1'b1;
                    end else begin
                        state_w = aud_pkg::P_WAIT_L;
                    end
                end
            end
            aud_pkg::P_WAIT_L: begin
                if (lrck_fall) begin
                    state_w   = aud_pkg::P_SHIFT_L;
                    bit_cnt_w = 4'hf;
                end
            end
            aud_pkg::P_SHIFT_L: begin
                dac_w     = i_rd_data[bit_cnt_r];
                bit_cnt_w = bit_cnt_r - 1'b1;
                if (bit_cnt_r == 4'h0) begin
                    state_w = aud_pkg::P_WAIT_R;
                end
            end
            aud_pkg::P_WAIT_R: begin
                if (lrck_rise) begin
                    state_w   = aud_pkg::P_SHIFT_R;
                    bit_cnt_w = 4'hf;
                end
            end
            aud_pkg::P_SHIFT_R: begin
                dac_w     = i_rd_data[bit_cnt_r];
                bit_cnt_w = bit_cnt_r - 1'b1;
                if (bit_cnt_r == 4'h0) begin
                    if (last_word) begin
                        done_w  = 1'b1;
                        state_w = aud_pkg::P_IDLE;
                    end else begin
                        addr_w  = o_rd_addr + 1'b1;   // prefetch during right idle time
                        state_w = aud_pkg::P_WAIT_L;
                    end
                end
            end
            aud_pkg::P_PAUSE: begin
                if (i_stop) begin
                    state_w = aud_pkg::P_IDLE;
                end else if (i_start) begin
                    state_w = aud_pkg::P_WAIT_L;
                end
            end
            default: state_w = aud_pkg::P_IDLE;
        endcase

        // stop and pause override whatever the shifter was doing
        if (active && (i_stop || i_pause)) begin
            state_w = i_stop ? aud_pkg::P_IDLE : aud_pkg::P_PAUSE;
            addr_w  = o_rd_addr;
            dac_w   = 1'b0;
            done_w  = 1'b0;
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= aud_pkg::P_IDLE;
            bit_cnt_r <= 4'hf;
            o_rd_addr <= '0;
            o_dacdat  <= 1'b0;
            o_done    <= 1'b0;
            lrck_d_r  <= 1'b0;
        end else begin
            state_r   <= state_w;
            bit_cnt_r <= bit_cnt_w;
            o_rd_addr <= addr_w;
            o_dacdat  <= dac_w;
            o_done    <= done_w;
            lrck_d_r  <= i_daclrck;
        end
    end

endmodule

// File: verilog/aud_cmd_ctrl.sv
`timescale 1ns/1ps

module aud_cmd_ctrl (
    input  logic                i_bclk,
    input  logic                i_rst_n,
    input  logic                i_cmd_req,
    input  aud_pkg::aud_op_e    i_cmd_op,
    input  logic                i_full,
    input  logic                i_done,
    output logic                o_cmd_ack,
    output aud_pkg::aud_mode_e  o_mode,
    output logic                o_rec_start,
    output logic                o_ply_start,
    output logic                o_pause,
    output logic                o_stop
);

    aud_pkg::aud_mode_e  mode_eff, mode_w;
    logic                ctx_play_r, ctx_play_w;
    logic                ack_w;
    logic                rec_start_w, ply_start_w, pause_w, stop_w;
    logic                accept;

    // new request only counts once the previous ack has dropped
    assign accept = i_cmd_req & ~o_cmd_ack;

    always_comb begin
        mode_eff = o_mode;
        if ((i_full && o_mode == aud_pkg::MODE_REC) ||
            (i_done && o_mode == aud_pkg::MODE_PLAY)) begin
            mode_eff = aud_pkg::MODE_IDLE;
        end

        mode_w      = mode_eff;
        ctx_play_w  = ctx_play_r;
        ack_w       = o_cmd_ack;
        rec_start_w = 1'b0;
        ply_start_w = 1'b0;
        pause_w     = 1'b0;
        stop_w      = 1'b0;

        if (accept) begin
            ack_w = 1'b1;
            case (i_cmd_op)
                aud_pkg::OP_RECORD, aud_pkg::OP_PLAY: begin
                    if (mode_eff == aud_pkg::MODE_IDLE) begin
                        if (i_cmd_op == aud_pkg::OP_RECORD) begin
                            mode_w      = aud_pkg::MODE_REC;
                            rec_start_w = 1'b1;
                        end else begin
                            mode_w      = aud_pkg::MODE_PLAY;
                            ply_start_w = 1'b1;
                        end
                    end else if (mode_eff == aud_pkg::MODE_PAUSE) begin
                        // either opcode resumes what was paused
                        if (ctx_play_r) begin
                            mode_w      = aud_pkg::MODE_PLAY;
                            ply_start_w = 1'b1;
                        end else begin
                            mode_w      = aud_pkg::MODE_REC;
                            rec_start_w = 1'b1;
                        end
                    end
                end
                aud_pkg::OP_PAUSE: begin
                    if (mode_eff == aud_pkg::MODE_REC || mode_eff == aud_pkg::MODE_PLAY) begin
                        mode_w     = aud_pkg::MODE_PAUSE;
                        pause_w    = 1'b1;
                        ctx_play_w = (mode_eff == aud_pkg::MODE_PLAY);
                    end
                end
                aud_pkg::OP_STOP: begin
                    mode_w = aud_pkg::MODE_IDLE;
                    stop_w = 1'b1;
                end
                default: ;
            endcase
        end else if (!i_cmd_req) begin
            ack_w = 1'b0;
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mode      <= aud_pkg::MODE_IDLE;
            ctx_play_r  <= 1'b0;
            o_cmd_ack   <= 1'b0;
            o_rec_start <= 1'b0;
            o_ply_start <= 1'b0;
            o_pause     <= 1'b0;
            o_stop      <= 1'b0;
        end else begin
            o_mode      <= mode_w;
            ctx_play_r  <= ctx_play_w;
            o_cmd_ack   <= ack_w;
            o_rec_start <= rec_start_w;   // same edge as ack
            o_ply_start <= ply_start_w;
            o_pause     <= pause_w;
            o_stop      <= stop_w;
        end
    end

endmodule

// File: verilog/aud_top.sv
`timescale 1ns/1ps

module aud_top (
    input  logic                      i_bclk,
    input  logic                      i_rst_n,
    input  logic                      i_daclrck,
    input  logic                      i_adcdat,
    input  logic                      i_cmd_req,
    input  aud_pkg::aud_op_e          i_cmd_op,
    output logic                      o_cmd_ack,
    output aud_pkg::aud_mode_e        o_mode,
    output logic                      o_dacdat,
    output logic [aud_pkg::ADDR_W:0]  o_rec_len
);

    logic                          rec_start, ply_start, pause, stop;
    logic                          full, done;
    logic                          wr_en;
    logic [aud_pkg::ADDR_W-1:0]    wr_addr, rd_addr;
    logic [aud_pkg::SAMPLE_W-1:0]  wr_data, rd_data;

    aud_cmd_ctrl u_ctrl (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .i_cmd_req   (i_cmd_req),
        .i_cmd_op    (i_cmd_op),
        .i_full      (full),
        .i_done      (done),
        .o_cmd_ack   (o_cmd_ack),
        .o_mode      (o_mode),
        .o_rec_start (rec_start),
        .o_ply_start (ply_start),
        .o_pause     (pause),
        .o_stop      (stop)
    );

    aud_recorder u_rec (
        .i_bclk    (i_bclk),
        .i_rst_n   (i_rst_n),
        .i_daclrck (i_daclrck),
        .i_adcdat  (i_adcdat),
        .i_start   (rec_start),
        .i_pause   (pause),
        .i_stop    (stop),
        .o_wr_en   (wr_en),
        .o_wr_addr (wr_addr),
        .o_wr_data (wr_data),
        .o_rec_len (o_rec_len),
        .o_full    (full)
    );

    // player length comes straight from the recorder count
    aud_player u_ply (
        .i_bclk    (i_bclk),
        .i_rst_n   (i_rst_n),
        .i_daclrck (i_daclrck),
        .i_start   (ply_start),
        .i_pause   (pause),
        .i_stop    (stop),
        .i_rec_len (o_rec_len),
        .i_rd_data (rd_data),
        .o_rd_addr (rd_addr),
        .o_dacdat  (o_dacdat),
        .o_done    (done)
    );

    aud_sample_buf u_buf (
        .i_bclk    (i_bclk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

endmodule

// File: testbench/aud_chk.sv
`timescale 1ns/1ps

module aud_chk (
    input logic                        i_clk,
    input logic                        i_rst_n,
    input logic                        i_req,
    input logic                        i_ack,
    input logic                        i_wr_en,
    input logic [aud_pkg::ADDR_W-1:0]  i_wr_addr
);

    int fail_cnt = 0;

    // four-phase host port
    ack_needs_req: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_ack) |-> i_req
    ) else begin
        fail_cnt++;
        $error("ack rose without req");
    end

    req_waits_ack_low: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_req) |-> !i_ack
    ) else begin
        fail_cnt++;
        $error("req rose while ack high");
    end

    wr_addr_in_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_wr_en |-> !$isunknown(i_wr_addr) && (i_wr_addr < aud_pkg::DEPTH)
    ) else begin
        fail_cnt++;
        $error("write address unknown or out of range");
    end

endmodule

bind aud_cmd_ctrl aud_chk u_chk_ctrl (
    .i_clk     (i_bclk),
    .i_rst_n   (i_rst_n),
    .i_req     (i_cmd_req),
    .i_ack     (o_cmd_ack),
    .i_wr_en   (1'b0),
    .i_wr_addr ('0)
);

// buffer has no reset of its own
bind aud_sample_buf aud_chk u_chk_buf (
    .i_clk     (i_bclk),
    .i_rst_n   (1'b1),
    .i_req     (1'b0),
    .i_ack     (1'b0),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr)
);

// File: testbench/tb_aud.sv
`timescale 1ns/1ps

module tb_aud;

    localparam int CLK_NS    = 40;
    localparam int HALF_BITS = 32;      // lrck half period in bit clocks
    localparam int MAX_FRAMES = 1024;
    localparam int T1_FRAMES = 45;
    localparam int T2_FRAMES = 40;
    localparam int T3_FRAMES = 20;
    localparam int T4_FRAMES = 260;
    localparam int T5_FRAMES = 8;
    localparam int ALL_FRAMES = T1_FRAMES + T2_FRAMES + T3_FRAMES + T4_FRAMES + T5_FRAMES;
    localparam longint WATCHDOG_NS = longint'(ALL_FRAMES + 40) * 2 * HALF_BITS * CLK_NS;

    logic                            bclk;
    logic                            rst_n;
    logic                            daclrck;
    logic                            adcdat;
    logic                            cmd_req;
    aud_pkg::aud_op_e                cmd_op;
    logic                            cmd_ack;
    aud_pkg::aud_mode_e              mode;
    logic                            dacdat;
    logic [aud_pkg::ADDR_W:0]        rec_len;

    // codec model state
    int                              pos;
    int                              frame;
    logic [aud_pkg::SAMPLE_W-1:0]    left_s [0:MAX_FRAMES-1];
    logic [2*HALF_BITS-1:0]          noise_s [0:MAX_FRAMES-1];   // filler and right channel bits

    // playback checking
    logic [aud_pkg::SAMPLE_W-1:0]    exp_q [$];
    logic [aud_pkg::SAMPLE_W-1:0]    dac_word;
    bit                              play_en;
    bit                              mute;
    int                              idx;
    int                              f;
    int                              chk_fails;

    aud_top dut (
        .i_bclk    (bclk),
        .i_rst_n   (rst_n),
        .i_daclrck (daclrck),
        .i_adcdat  (adcdat),
        .i_cmd_req (cmd_req),
        .i_cmd_op  (cmd_op),
        .o_cmd_ack (cmd_ack),
        .o_mode    (mode),
        .o_dacdat  (dacdat),
        .o_rec_len (rec_len)
    );

    assign chk_fails = dut.u_ctrl.u_chk_ctrl.fail_cnt + dut.u_buf.u_chk_buf.fail_cnt;

    always #(CLK_NS / 2) bclk = ~bclk;

    // codec: lrck low is left, sample MSB at bit 1 of the left half
    always @(posedge bclk) begin
        #2;
        if (pos == HALF_BITS - 1) begin
            pos     = 0;
            daclrck = ~daclrck;
            if (!daclrck) begin
                frame = frame + 1;
            end
        end else begin
            pos = pos + 1;
        end
        if (!daclrck && pos >= 1 && pos <= aud_pkg::SAMPLE_W) begin
            adcdat = left_s[frame][aud_pkg::SAMPLE_W - pos];
        end else begin
            adcdat = noise_s[frame][daclrck ? HALF_BITS + pos : pos];
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // expected samples for a run of recorded frames
    function automatic void ref_append(input int start_frame, input int count);
        for (int i = 0; i < count; i++) begin
            exp_q.push_back(left_s[start_frame + i]);
        end
    endfunction

    // monitor and compare, bits sit at positions 2..17 of each half
    always @(negedge bclk) begin
        if (pos >= 2 && pos <= aud_pkg::SAMPLE_W + 1) begin
            dac_word = {dac_word[aud_pkg::SAMPLE_W-2:0], dacdat};
        end else if (pos == aud_pkg::SAMPLE_W + 2 && play_en) begin
            if (mute || idx >= exp_q.size()) begin
                check_equal(dac_word, '0, "silent word");
            end else begin
                check_equal(dac_word, exp_q[idx], daclrck ? "right word" : "left word");
                if (daclrck) begin
                    idx++;
                end
            end
        end
    end

    // assertion failures in the bound checkers
    always @(negedge bclk) begin
        if (chk_fails != 0) begin
            $display("a bound assertion failed at %0t ns", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end
    end

    task automatic host_cmd(input aud_pkg::aud_op_e op);
        @(posedge bclk);
        #2;
        cmd_op  = op;
        cmd_req = 1'b1;
        do @(negedge bclk); while (!cmd_ack);
        @(posedge bclk);
        #2;
        cmd_req = 1'b0;
        do @(negedge bclk); while (cmd_ack);
    endtask

    task automatic wait_at(input int fr, input logic lr, input int p);
        do @(negedge bclk); while (!(frame == fr && daclrck == lr && pos == p));
    endtask

    // middle of the right half, clear of any shifting
    task automatic wait_right();
        do @(negedge bclk); while (!(daclrck && pos == 20));
    endtask

    task automatic wait_idle();
        do @(negedge bclk); while (mode != aud_pkg::MODE_IDLE);
    endtask

    task automatic play_and_check();
        wait_right();
        idx     = 0;
        play_en = 1'b1;
        host_cmd(aud_pkg::OP_PLAY);
        wait_idle();
        wait_right();   // last right word is compared at pos 18
        play_en = 1'b0;
        check_equal(idx, exp_q.size(), "played sample count");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'hd1b19354));
        for (int i = 0; i < MAX_FRAMES; i++) begin
            left_s[i]  = $urandom();
            noise_s[i] = {$urandom(), $urandom()};
        end
        bclk     = 1'b0;
        rst_n    = 1'b0;
        daclrck  = 1'b1;
        adcdat   = 1'b0;
        cmd_req  = 1'b0;
        cmd_op   = aud_pkg::OP_STOP;
        pos      = HALF_BITS - 1;
        frame    = -1;
        dac_word = '0;
        play_en  = 1'b0;
        mute     = 1'b0;
        idx      = 0;
        repeat (3) @(posedge bclk);
        #2;
        rst_n = 1'b1;

        @(negedge bclk);
        check_equal(cmd_ack, 0, "ack after reset");
        check_equal(dacdat, 0, "dacdat after reset");
        check_equal(rec_len, 0, "rec_len after reset");
        check_equal(mode, aud_pkg::MODE_IDLE, "mode after reset");

        // record 20 frames, then play back
        wait_right();
        f = frame;
        host_cmd(aud_pkg::OP_RECORD);
        wait_at(f + 20, 1'b1, 20);
        host_cmd(aud_pkg::OP_STOP);
        check_equal(rec_len, 20, "rec_len after 20 frames");
        exp_q.delete();
        ref_append(f + 1, 20);
        play_and_check();

        // pause in the middle of a left half, partial sample is lost
        wait_right();
        f = frame;
        host_cmd(aud_pkg::OP_RECORD);
        wait_at(f + 5, 1'b0, 6);
        host_cmd(aud_pkg::OP_PAUSE);
        check_equal(mode, aud_pkg::MODE_PAUSE, "mode after record pause");
        wait_at(f + 9, 1'b1, 20);
        host_cmd(aud_pkg::OP_RECORD);
        wait_at(f + 19, 1'b1, 20);
        host_cmd(aud_pkg::OP_STOP);
        check_equal(rec_len, 14, "rec_len after paused recording");
        exp_q.delete();
        ref_append(f + 1, 4);
        ref_append(f + 10, 10);
        play_and_check();

        // pause during playback
        wait_right();
        f       = frame;
        idx     = 0;
        play_en = 1'b1;
        host_cmd(aud_pkg::OP_PLAY);
        wait_at(f + 4, 1'b1, 20);
        mute = 1'b1;
        host_cmd(aud_pkg::OP_PAUSE);
        wait_at(f + 8, 1'b1, 20);
        check_equal(idx, 4, "samples played before pause");
        mute = 1'b0;
        host_cmd(aud_pkg::OP_PLAY);
        wait_idle();
        wait_right();
        play_en = 1'b0;
        check_equal(idx, exp_q.size(), "played count after pause");

        // stop in the middle of a left word
        wait_right();
        f = frame;
        host_cmd(aud_pkg::OP_PLAY);
        wait_at(f + 3, 1'b0, 8);
        host_cmd(aud_pkg::OP_STOP);
        check_equal(mode, aud_pkg::MODE_IDLE, "mode after stop");
        repeat (2 * HALF_BITS) begin
            @(negedge bclk);
            check_equal(dacdat, 0, "dacdat after stop");
        end
        host_cmd(aud_pkg::OP_PAUSE);   // not applicable in idle
        check_equal(mode, aud_pkg::MODE_IDLE, "mode after pause in idle");
        check_equal(rec_len, 14, "rec_len after pause in idle");

        // fill the whole buffer
        wait_right();
        f = frame;
        host_cmd(aud_pkg::OP_RECORD);
        wait_idle();
        check_equal(frame, f + aud_pkg::DEPTH, "frame when buffer filled");
        check_equal(rec_len, aud_pkg::DEPTH, "rec_len when full");

        if (chk_fails == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: tb.f
verilog/aud_pkg.sv
verilog/aud_sample_buf.sv
verilog/aud_recorder.sv
verilog/aud_player.sv
verilog/aud_cmd_ctrl.sv
verilog/aud_top.sv
testbench/aud_chk.sv
testbench/tb_aud.sv

// File: Bender.yml
package:
  name: aud_rec_play

sources:
  - verilog/aud_pkg.sv
  - verilog/aud_sample_buf.sv
  - verilog/aud_recorder.sv
  - verilog/aud_player.sv
  - verilog/aud_cmd_ctrl.sv
  - verilog/aud_top.sv
  - target: test
    files:
      - testbench/aud_chk.sv
      - testbench/tb_aud.sv
